// ==== common/lsu_pkg.sv ====
package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int data_width = 32;              // memory and register word
  parameter int be_width   = data_width / 8;  // one enable per byte lane

  ////////////////////////////////////////////////////////////////////////////
  // data type codes from the EX stage
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] type_word = 2'b00;
  localparam logic [1:0] type_half = 2'b01;
  localparam logic [1:0] type_byte = 2'b10;  // 2'b11 is a byte as well

  // one memory word, seen as byte lanes or as halfword lanes
  // lane 0 is the least significant, lanes follow addr[1:0]
  typedef union packed {
    logic [be_width-1:0][7:0]      bytes;   // byte lane per address offset
    logic [be_width/2-1:0][15:0]   halves;  // halfword lane per addr[1]
  } lsu_word_u;

endpackage

// ==== source/lsu_store_path.sv ====
`timescale 1ns/1ps

module lsu_store_path #(
  parameter int addr_width = 32
) (
  // operands from the EX stage
  input  logic [addr_width-1:0]           operand_a_i,     // base register
  input  logic [addr_width-1:0]           operand_b_i,     // offset or immediate
  input  logic                            addr_useincr_i,  // low: a alone, post-increment
  input  logic [1:0]                      data_type_i,
  input  logic [lsu_pkg::data_width-1:0]  data_wdata_i,    // store data, low aligned

  // towards memory and the load path
  output logic [addr_width-1:0]           data_addr_o,
  output logic [1:0]                      addr_offset_o,   // byte offset in the word
  output logic [lsu_pkg::be_width-1:0]    data_be_o,
  output logic [lsu_pkg::data_width-1:0]  data_wdata_o     // store data in its lanes
);

  import lsu_pkg::*;

  logic [addr_width-1:0] data_addr;
  logic [1:0]            offset;
  lsu_word_u             wdata_raw;   // register view of store data
  lsu_word_u             wdata_rot;   // memory view after rotation

  // address adder, a alone for post-increment accesses
  assign data_addr = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign offset    = data_addr[1:0];  // only these bits steer the lanes

  ////////////////////////////////////////////////////////////////////////////
  // byte enables, aligned accesses only
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_i)
      type_word:        data_be_o = '1;                                 // all lanes
      type_half:        data_be_o = offset[1] ? 4'b1100 : 4'b0011;      // upper or lower pair
      type_byte, 2'b11: data_be_o = 4'b0001 << offset;                  // single lane
    endcase
  end

  // rotate left by offset bytes
  // low bytes of the register land in the enabled lanes
  assign wdata_raw = data_wdata_i;

  always_comb
  begin
    wdata_rot = '0;  // every lane is written by the loop
    for (int i = 0; i < be_width; i++)
    begin
      wdata_rot.bytes[(i + offset) % be_width] = wdata_raw.bytes[i];
    end
  end

  assign data_addr_o   = data_addr;
  assign addr_offset_o = offset;
  assign data_wdata_o  = wdata_rot;

endmodule

// ==== source/lsu_load_path.sv ====
`timescale 1ns/1ps

module lsu_load_path (
  input  logic                            clk,
  input  logic                            rst_n,

  // handshake from memory
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,

  // access attributes, valid in the grant cycle
  input  logic                            data_we_i,
  input  logic                            data_sign_ext_i,
  input  logic [1:0]                      data_type_i,
  input  logic [1:0]                      addr_offset_i,

  input  logic [lsu_pkg::data_width-1:0]  data_rdata_i,     // raw word from memory
  output logic [lsu_pkg::data_width-1:0]  data_rdata_ex_o   // aligned, extended result
);

  import lsu_pkg::*;

  // attributes of the access in flight
  logic [1:0]            data_type_q;
  logic [1:0]            rdata_offset_q;
  logic                  sign_ext_q;
  logic                  we_q;

  lsu_word_u             rdata_u;      // read word, lane views
  logic [15:0]           rdata_half;   // addressed halfword
  logic [7:0]            rdata_byte;   // addressed byte
  logic [data_width-1:0] rdata_ext;    // extended live value
  logic [data_width-1:0] rdata_q;      // held result while EX stalls

  // capture on grant, the read data comes back later
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_type_q    <= type_word;
      rdata_offset_q <= '0;
      sign_ext_q     <= 1'b0;
      we_q           <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      data_type_q    <= data_type_i;
      rdata_offset_q <= addr_offset_i;
      sign_ext_q     <= data_sign_ext_i;
      we_q           <= data_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane select and extension
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_u    = data_rdata_i;
  assign rdata_half = rdata_u.halves[rdata_offset_q[1]];  // aligned pair only
  assign rdata_byte = rdata_u.bytes[rdata_offset_q];

  always_comb
  begin
    case (data_type_q)
      type_word:                                          // word passes unchanged
        rdata_ext = rdata_u;
      type_half:
        rdata_ext = {{(data_width-16){sign_ext_q & rdata_half[15]}}, rdata_half};
      type_byte, 2'b11:
        rdata_ext = {{(data_width-8){sign_ext_q & rdata_byte[7]}}, rdata_byte};
    endcase
  end

  // result hold register, loads only on load responses
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata_q <= '0;
    end
    else if (data_rvalid_i && !we_q)
    begin
      rdata_q <= rdata_ext;
    end
  end

  // live value in the rvalid cycle, held copy afterwards
  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

// ==== source/lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl (
  input  logic clk,
  input  logic rst_n,

  // EX stage side
  input  logic data_req_ex_i,
  input  logic data_we_i,
  input  logic ex_valid_i,      // low while EX is stalled

  // memory handshake
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,      // only with gnt
  output logic data_req_o,

  // status
  output logic lsu_ready_ex_o,
  output logic lsu_ready_wb_o,
  output logic busy_o,
  output logic load_err_o,
  output logic store_err_o
);

  localparam logic [1:0] IDLE                 = 2'd0;
  localparam logic [1:0] WAIT_RVALID          = 2'd1;
  localparam logic [1:0] WAIT_RVALID_EX_STALL = 2'd2;
  localparam logic [1:0] IDLE_EX_STALL        = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      IDLE:
      begin
        if (data_req_ex_i)
        begin
          data_req_o     = 1'b1;
          lsu_ready_ex_o = data_gnt_i;  // EX holds until granted
          if (data_gnt_i)
            state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
        end
      end

      // response pending, next request may overlap with rvalid
      WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        if (data_rvalid_i)
        begin
          state_d = IDLE;
          if (data_req_ex_i)
          begin
            data_req_o     = 1'b1;
            lsu_ready_ex_o = data_gnt_i;
            if (data_gnt_i)
              state_d = ex_valid_i ? WAIT_RVALID : WAIT_RVALID_EX_STALL;
          end
        end
      end

      // EX stalled at grant, no new request from here
      WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
          state_d = ex_valid_i ? IDLE : IDLE_EX_STALL;  // result already held
        else if (ex_valid_i)
          state_d = WAIT_RVALID;                        // back to normal wait
      end

      // data is in, EX still stalled
      IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  // bus errors come with the grant, split by direction
  assign load_err_o  = data_gnt_i & data_err_i & ~data_we_i;
  assign store_err_o = data_gnt_i & data_err_i & data_we_i;

  assign busy_o = (state_q != IDLE) | data_req_o;  // any access in flight

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit #(
  parameter int addr_width = 32
) (
  input  logic                            clk,
  input  logic                            rst_n,

  // EX stage request
  input  logic                            data_req_ex_i,
  input  logic                            data_we_ex_i,
  input  logic [1:0]                      data_type_ex_i,      // word, half, byte
  input  logic                            data_sign_ext_ex_i,
  input  logic [lsu_pkg::data_width-1:0]  data_wdata_ex_i,
  input  logic [addr_width-1:0]           operand_a_ex_i,
  input  logic [addr_width-1:0]           operand_b_ex_i,
  input  logic                            addr_useincr_ex_i,
  input  logic                            ex_valid_i,

  // EX stage results and status
  output logic [lsu_pkg::data_width-1:0]  data_rdata_ex_o,
  output logic                            lsu_ready_ex_o,
  output logic                            lsu_ready_wb_o,
  output logic                            busy_o,
  output logic                            load_err_o,
  output logic                            store_err_o,

  // data memory port
  output logic                            data_req_o,
  output logic [addr_width-1:0]           data_addr_o,
  output logic                            data_we_o,
  output logic [lsu_pkg::be_width-1:0]    data_be_o,
  output logic [lsu_pkg::data_width-1:0]  data_wdata_o,
  input  logic                            data_gnt_i,
  input  logic                            data_rvalid_i,
  input  logic                            data_err_i,
  input  logic [lsu_pkg::data_width-1:0]  data_rdata_i
);

  logic [1:0] addr_offset;  // byte offset, store path to load path

  assign data_we_o = data_we_ex_i;  // direction goes straight out

  lsu_store_path #(
    .addr_width (addr_width)
  ) i_lsu_store_path (
    .operand_a_i    (operand_a_ex_i),
    .operand_b_i    (operand_b_ex_i),
    .addr_useincr_i (addr_useincr_ex_i),
    .data_type_i    (data_type_ex_i),
    .data_wdata_i   (data_wdata_ex_i),
    .data_addr_o    (data_addr_o),
    .addr_offset_o  (addr_offset),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o)
  );

  lsu_load_path i_lsu_load_path (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_gnt_i      (data_gnt_i),
    .data_rvalid_i   (data_rvalid_i),
    .data_we_i       (data_we_ex_i),
    .data_sign_ext_i (data_sign_ext_ex_i),
    .data_type_i     (data_type_ex_i),
    .addr_offset_i   (addr_offset),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

  lsu_ctrl i_lsu_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_we_i      (data_we_ex_i),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o)
  );

endmodule

// ==== sim/tb_load_store_unit.sv ====
`timescale 1ns/1ps

module tb_load_store_unit;

  localparam int max_vectors = 64;

  logic        clk;
  logic        rst_n;
  logic        data_req_ex_i, data_we_ex_i, data_sign_ext_ex_i, addr_useincr_ex_i, ex_valid_i;
  logic [1:0]  data_type_ex_i;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i;
  logic [31:0] data_rdata_ex_o, data_addr_o, data_wdata_o, data_rdata_i;
  logic        lsu_ready_ex_o, lsu_ready_wb_o, busy_o, load_err_o, store_err_o;
  logic        data_req_o, data_we_o, data_gnt_i, data_rvalid_i, data_err_i;
  logic [3:0]  data_be_o;

  // vector table, one entry per line of the data file
  string       vec_name [0:max_vectors-1];
  logic [31:0] vec_field [0:max_vectors-1][0:12];  // columns after the name
  int          vec_count;

  int          cycle_count = 0;
  int          cycle_limit = 20;   // grows with the vector count
  int          test_errors;
  int          pass_count = 0;
  int          fail_count = 0;

  load_store_unit #(
    .addr_width (32)
  ) i_load_store_unit (
    .clk                (clk),
    .rst_n              (rst_n),
    .data_req_ex_i      (data_req_ex_i),
    .data_we_ex_i       (data_we_ex_i),
    .data_type_ex_i     (data_type_ex_i),
    .data_sign_ext_ex_i (data_sign_ext_ex_i),
    .data_wdata_ex_i    (data_wdata_ex_i),
    .operand_a_ex_i     (operand_a_ex_i),
    .operand_b_ex_i     (operand_b_ex_i),
    .addr_useincr_ex_i  (addr_useincr_ex_i),
    .ex_valid_i         (ex_valid_i),
    .data_rdata_ex_o    (data_rdata_ex_o),
    .lsu_ready_ex_o     (lsu_ready_ex_o),
    .lsu_ready_wb_o     (lsu_ready_wb_o),
    .busy_o             (busy_o),
    .load_err_o         (load_err_o),
    .store_err_o        (store_err_o),
    .data_req_o         (data_req_o),
    .data_addr_o        (data_addr_o),
    .data_we_o          (data_we_o),
    .data_be_o          (data_be_o),
    .data_wdata_o       (data_wdata_o),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_err_i         (data_err_i),
    .data_rdata_i       (data_rdata_i)
  );

  always #20 clk = ~clk;  // 40 ns period

  // watchdog, counts every cycle of the run
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout: run hung waiting for grant or rvalid after %0d cycles", cycle_count);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("Error %s %s: expected %h actual %h", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string test_name);
    if (test_errors == 0)
    begin
      $display("%s: ok", test_name);
      pass_count++;
    end
    else
    begin
      $display("%s: %0d mismatches", test_name, test_errors);
      fail_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one access, memory model answers with random delays
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_vector(input int idx);
    string       nm;
    int          grant_delay, rvalid_delay, stall_len;
    logic        we, err;
    logic [31:0] rword, exp_rd;
    nm           = vec_name[idx];
    we           = vec_field[idx][0][0];
    rword        = vec_field[idx][7];
    err          = vec_field[idx][8][0];
    exp_rd       = vec_field[idx][12];
    test_errors  = 0;
    grant_delay  = $urandom_range(2, 0);
    rvalid_delay = $urandom_range(3, 1);
    stall_len    = $urandom_range(2, 0);
    @(negedge clk);
    data_req_ex_i      = 1'b1;
    data_we_ex_i       = we;
    data_type_ex_i     = vec_field[idx][1][1:0];
    data_sign_ext_ex_i = vec_field[idx][2][0];
    addr_useincr_ex_i  = vec_field[idx][3][0];
    operand_a_ex_i     = vec_field[idx][4];
    operand_b_ex_i     = vec_field[idx][5];
    data_wdata_ex_i    = vec_field[idx][6];
    ex_valid_i         = (stall_len == 0);  // EX stalled across the whole access
    repeat (grant_delay)
    begin
      #5;
      check_value(nm, "req while no grant", 1, data_req_o);
      check_value(nm, "ready_ex while no grant", 0, lsu_ready_ex_o);
      @(negedge clk);
    end
    data_gnt_i = 1'b1;
    data_err_i = err;
    #5;  // grant cycle, memory side fields
    check_value(nm, "addr", vec_field[idx][9], data_addr_o);
    check_value(nm, "be", vec_field[idx][10], data_be_o);
    check_value(nm, "wdata", vec_field[idx][11], data_wdata_o);
    check_value(nm, "we", we, data_we_o);
    check_value(nm, "ready_ex at grant", 1, lsu_ready_ex_o);
    check_value(nm, "load_err", err & ~we, load_err_o);
    check_value(nm, "store_err", err & we, store_err_o);
    @(negedge clk);
    data_gnt_i = 1'b0;
    data_err_i = 1'b0;
    if (stall_len == 0)
      data_req_ex_i = 1'b0;  // stalled EX keeps asking, must be blocked
    repeat (rvalid_delay - 1)
    begin
      #5;
      check_value(nm, "second req", 0, data_req_o);
      check_value(nm, "busy while waiting", 1, busy_o);
      if (stall_len == 0)
        check_value(nm, "ready_wb while waiting", 0, lsu_ready_wb_o);
      @(negedge clk);
    end
    data_rvalid_i = 1'b1;
    data_rdata_i  = rword;
    #5;
    check_value(nm, "req at rvalid", 0, data_req_o);
    if (!we)
      check_value(nm, "live rdata", exp_rd, data_rdata_ex_o);
    @(negedge clk);
    data_rvalid_i = 1'b0;
    data_rdata_i  = ~rword;  // stale bus, result must come from the hold reg
    repeat (stall_len)
    begin
      #5;
      check_value(nm, "busy in stall", 1, busy_o);
      check_value(nm, "req in stall", 0, data_req_o);
      @(negedge clk);
    end
    data_req_ex_i = 1'b0;
    ex_valid_i    = 1'b1;
    #5;
    while (busy_o)  // back to idle, watchdog guards this
    begin
      @(negedge clk);
      #5;
    end
    if (!we)
      check_value(nm, "held rdata", exp_rd, data_rdata_ex_o);
    finish_test(nm);
  endtask

  initial
  begin
    int          fd, n, seed;
    string       line, nm;
    logic [31:0] f [0:12];
    clk = 1'b0;
    rst_n = 1'b0;
    data_req_ex_i = 1'b0;
    data_we_ex_i = 1'b0;
    data_type_ex_i = 2'b00;
    data_sign_ext_ex_i = 1'b0;
    addr_useincr_ex_i = 1'b1;
    ex_valid_i = 1'b1;
    data_wdata_ex_i = '0;
    operand_a_ex_i = '0;
    operand_b_ex_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i = 1'b0;
    data_rdata_i = '0;
    seed = $urandom(32'hc641);
    vec_count = 0;
    fd = $fopen("sim/lsu_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file sim/lsu_vectors.txt");
      $display("Some tests failed");
      $finish;
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        if (line.len() < 2 || line.getc(0) == "#")
          continue;  // comment or blank line
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", nm, f[0], f[1],
                    f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        if (n != 14 || vec_count >= max_vectors)
        begin
          $display("Vector file line could not be read: %s", line);
          fail_count++;
        end
        else
        begin
          vec_name[vec_count] = nm;
          for (int i = 0; i < 13; i++)
            vec_field[vec_count][i] = f[i];
          vec_count++;
        end
      end
      $fclose(fd);
      cycle_limit = vec_count * 12 + 20;

      // reset and idle state
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      #5;
      test_errors = 0;
      check_value("reset", "req", 0, data_req_o);
      check_value("reset", "busy", 0, busy_o);
      check_value("reset", "load_err", 0, load_err_o);
      check_value("reset", "store_err", 0, store_err_o);
      check_value("reset", "ready_ex", 1, lsu_ready_ex_o);
      check_value("reset", "ready_wb", 1, lsu_ready_wb_o);
      check_value("reset", "rdata", 0, data_rdata_ex_o);
      finish_test("reset");

      for (int v = 0; v < vec_count; v++)
        run_vector(v);

      $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
      if (fail_count == 0)
        $display("All tests passed");
      else
        $display("Some tests failed");
      $finish;
    end
  end

endmodule

// ==== sim/lsu_vectors.txt ====
# name we type sign useincr op_a op_b wdata mem_word err exp_addr exp_be exp_wdata exp_rdata
# all hex; type 0 word, 1 half, 2 or 3 byte; exp_rdata only used for loads
sw_off0 1 0 0 1 00001000 00000010 11223344 00000000 0 00001010 f 11223344 00000000
sh_off2 1 1 0 1 00002000 00000002 0000beef 00000000 0 00002002 c beef0000 00000000
sh_off0 1 1 0 1 00002004 00000000 cafe1234 00000000 0 00002004 3 cafe1234 00000000
sb_off1 1 2 0 1 00003000 00000001 aabbccdd 00000000 0 00003001 2 bbccddaa 00000000
sb_off3_noincr 1 3 0 0 00003003 00000100 12345678 00000000 0 00003003 8 78123456 00000000
sb_off2 1 2 0 1 00004000 00000002 000000a5 00000000 0 00004002 4 00a50000 00000000
lw_off0 0 0 0 1 00005000 00000008 00000000 deadbeef 0 00005008 f 00000000 deadbeef
lh_sext_off2 0 1 1 1 00005000 00000006 00000000 80017ffe 0 00005006 c 00000000 ffff8001
lhu_off0 0 1 0 1 00005010 00000000 00000000 1234f00d 0 00005010 3 00000000 0000f00d
lb_sext_off1 0 2 1 1 00006000 00000001 00000000 11228033 0 00006001 2 00000000 ffffff80
lbu_off3_noincr 0 2 0 0 00006003 00000010 00000000 9abcdef0 0 00006003 8 00000000 0000009a
lb_sext_pos_off2 0 3 1 1 00006000 00000002 00000000 00700000 0 00006002 4 00000000 00000070
lw_bus_err 0 0 0 1 00007000 00000004 00000000 00000000 1 00007004 f 00000000 00000000
sw_bus_err 1 0 0 1 00007000 00000008 55aa55aa 00000000 1 00007008 f 55aa55aa 00000000

// ==== load_store_unit.f ====
common/lsu_pkg.sv
source/lsu_store_path.sv
source/lsu_load_path.sv
source/lsu_ctrl.sv
source/load_store_unit.sv
sim/tb_load_store_unit.sv

// ==== Bender.yml ====
package:
  name: load_store_unit

sources:
  # shared package first, then the blocks and the top level
  - common/lsu_pkg.sv
  - source/lsu_store_path.sv
  - source/lsu_load_path.sv
  - source/lsu_ctrl.sv
  - source/load_store_unit.sv
  - target: simulation
    files:
      - sim/tb_load_store_unit.sv
